//--- verilog/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int TAG_WIDTH      = 20;
    localparam int INDEX_WIDTH    = 8;
    localparam int OFFSET_WIDTH   = 4;
    localparam int WORD_WIDTH     = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;
    localparam int WAY_NUM        = 2;
    localparam int LINE_NUM       = 1 << INDEX_WIDTH;

    typedef logic [TAG_WIDTH-1:0]                  tag_t;
    typedef logic [INDEX_WIDTH-1:0]                index_t;
    typedef logic [OFFSET_WIDTH-1:0]               offset_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]     word_sel_t;
    typedef logic [LINE_WIDTH-1:0]                 line_t;
    typedef logic [WORD_WIDTH-1:0]                 word_t;
    typedef logic [$clog2(WAY_NUM)-1:0]            way_t;
    typedef logic [WAY_NUM-1:0]                    way_vec_t;

    // request ops, bit 2 marks cache maintenance
    typedef enum logic [2:0] {
        OP_READ       = 3'd0,
        OP_CACOP_IDX0 = 3'd4,
        OP_CACOP_IDX1 = 3'd5,
        OP_CACOP_HIT  = 3'd6,
        OP_CACOP_NOP  = 3'd7
    } op_t;

    // memory read types
    typedef enum logic [2:0] {
        RD_WORD = 3'd2,
        RD_LINE = 3'd4
    } rd_type_t;

    typedef struct packed {
        op_t     op;
        tag_t    tag;
        index_t  index;
        offset_t offset;
        logic    uncached;
    } cache_req_t;

    typedef struct packed {
        rd_type_t            rd_type;
        logic [WORD_WIDTH-1:0] addr;
    } mem_rd_t;

endpackage

//--- verilog/icache_way_ram.sv
module icache_way_ram #(
    parameter type entry_t = icache_pkg::line_t
) (
    input  logic               clk,
    input  icache_pkg::index_t addr,
    input  logic               we,
    input  entry_t             wdata,
    output entry_t             rdata
);

    entry_t mem [icache_pkg::LINE_NUM];

    // read returns the old entry when written in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

//--- verilog/icache_tag_store.sv
module icache_tag_store (
    input  logic                 clk,
    input  logic                 resetn,
    input  icache_pkg::index_t   read_index,
    input  icache_pkg::index_t   req_index,
    input  icache_pkg::tag_t     req_tag,
    output icache_pkg::way_vec_t hit_way,
    input  logic                 fill_en,
    input  icache_pkg::way_t     fill_way,
    input  logic                 inval_en,
    input  icache_pkg::way_t     inval_way
);

    for (genvar w = 0; w < icache_pkg::WAY_NUM; w++) begin : g_way
        icache_pkg::tag_t                  tag_q;
        logic [icache_pkg::LINE_NUM-1:0]   valid_q;
        logic                              sel_fill;
        logic                              sel_inval;

        assign sel_fill  = fill_en && fill_way == icache_pkg::way_t'(w);
        assign sel_inval = inval_en && inval_way == icache_pkg::way_t'(w);

        icache_way_ram #(
            .entry_t (icache_pkg::tag_t)
        ) tag_ram (
            .clk   (clk),
            .addr  (read_index),
            .we    (sel_fill),
            .wdata (req_tag),
            .rdata (tag_q)
        );

        // valid bits live in flops so reset can clear them
        always_ff @(posedge clk) begin
            if (!resetn) begin
                valid_q <= '0;
            end else if (fill_en) begin
                if (sel_fill) begin
                    valid_q[req_index] <= 1'b1;
                end
            end else if (sel_inval) begin
                valid_q[req_index] <= 1'b0;
            end
        end

        // tag_q was read at acceptance, so it matches req_index here
        assign hit_way[w] = valid_q[req_index] && tag_q == req_tag;
    end

endmodule

//--- verilog/icache_refill_buffer.sv
module icache_refill_buffer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              clear,
    input  logic              ret_valid,
    input  icache_pkg::word_t ret_data,
    output icache_pkg::line_t line
);

    icache_pkg::word_sel_t beat_cnt;
    icache_pkg::line_t     partial;

    // merge the beat in flight so the full line shows on the last beat
    always_comb begin
        line = partial;
        if (ret_valid) begin
            line[beat_cnt*icache_pkg::WORD_WIDTH +: icache_pkg::WORD_WIDTH] = ret_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (clear) begin
            beat_cnt <= '0;
        end else if (ret_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            partial <= '0;
        end else if (ret_valid) begin
            partial <= line;
        end
    end

endmodule

//--- verilog/icache_ctrl.sv
module icache_ctrl (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   valid,
    input  icache_pkg::cache_req_t req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output icache_pkg::word_t      rdata,
    output logic                   rd_req,
    output icache_pkg::mem_rd_t    rd,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  icache_pkg::word_t      ret_data,
    output icache_pkg::index_t     read_index,
    output icache_pkg::index_t     req_index,
    output icache_pkg::tag_t       req_tag,
    input  icache_pkg::way_vec_t   hit_way,
    output logic                   fill_en,
    output icache_pkg::way_t       fill_way,
    output logic                   inval_en,
    output icache_pkg::way_t       inval_way,
    input  icache_pkg::line_t      way_line [icache_pkg::WAY_NUM],
    output icache_pkg::way_vec_t   data_we,
    input  icache_pkg::line_t      refill_line,
    output logic                   buffer_clear
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_REFILL
    } state_t;

    state_t                 state;
    icache_pkg::cache_req_t req_q;
    logic                   rd_sent;
    icache_pkg::way_t       rr_ptr;
    logic                   lookup;
    logic                   refill;
    logic                   cacop;
    logic                   cached_hit;
    logic                   refill_done;
    icache_pkg::way_t       hit_id;
    icache_pkg::line_t      sel_line;
    icache_pkg::word_sel_t  word_sel;

    assign lookup      = state == ST_LOOKUP;
    assign refill      = state == ST_REFILL;
    assign cacop       = req_q.op != icache_pkg::OP_READ;
    assign cached_hit  = |hit_way && !req_q.uncached;
    assign refill_done = refill && ret_valid && ret_last;
    assign hit_id      = icache_pkg::way_t'(hit_way[1]);

    // accept when idle, or when the lookup in progress hits
    assign addr_ok    = valid && (state == ST_IDLE || (lookup && cached_hit));
    assign read_index = addr_ok ? req.index : req_q.index;
    assign req_index  = req_q.index;
    assign req_tag    = req_q.tag;

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (addr_ok) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (addr_ok) begin
                        state <= ST_LOOKUP;
                    end else if (cacop || cached_hit) begin
                        state <= ST_IDLE;
                    end else begin
                        state <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (refill_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // memory read, held until rd_rdy
    always_ff @(posedge clk) begin
        if (!resetn || !refill) begin
            rd_sent <= 1'b0;
        end else if (rd_rdy) begin
            rd_sent <= 1'b1;
        end
    end

    assign rd_req       = refill && !rd_sent;
    assign buffer_clear = rd_req;
    assign rd.rd_type   = req_q.uncached ? icache_pkg::RD_WORD : icache_pkg::RD_LINE;
    assign rd.addr      = req_q.uncached ? {req_q.tag, req_q.index, req_q.offset}
                                         : {req_q.tag, req_q.index, {icache_pkg::OFFSET_WIDTH{1'b0}}};

    // round robin victim, untouched by uncached reads
    always_ff @(posedge clk) begin
        if (!resetn) begin
            rr_ptr <= '0;
        end else if (fill_en) begin
            rr_ptr <= rr_ptr + 1'b1;
        end
    end

    assign fill_en  = refill_done && !req_q.uncached;
    assign fill_way = rr_ptr;
    assign data_we  = fill_en ? icache_pkg::way_vec_t'(1) << rr_ptr : '0;

    // maintenance acts during lookup
    assign inval_en = lookup && (req_q.op == icache_pkg::OP_CACOP_IDX0
                              || req_q.op == icache_pkg::OP_CACOP_IDX1
                              || (req_q.op == icache_pkg::OP_CACOP_HIT && |hit_way));
    assign inval_way = req_q.op == icache_pkg::OP_CACOP_HIT ? hit_id
                                                            : icache_pkg::way_t'(req_q.offset[0]);

    assign data_ok = (lookup && !cacop && cached_hit) || refill_done;

    assign sel_line = lookup ? way_line[hit_id] : refill_line;
    assign word_sel = req_q.offset[icache_pkg::OFFSET_WIDTH-1:2];
    assign rdata    = req_q.uncached ? ret_data
                    : sel_line[word_sel*icache_pkg::WORD_WIDTH +: icache_pkg::WORD_WIDTH];

endmodule

//--- verilog/icache_top.sv
module icache_top (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   valid,
    input  icache_pkg::cache_req_t req,
    output logic                   addr_ok,
    output logic                   data_ok,
    output icache_pkg::word_t      rdata,
    output logic                   rd_req,
    output icache_pkg::mem_rd_t    rd,
    input  logic                   rd_rdy,
    input  logic                   ret_valid,
    input  logic                   ret_last,
    input  icache_pkg::word_t      ret_data
);

    icache_pkg::index_t   read_index;
    icache_pkg::index_t   req_index;
    icache_pkg::tag_t     req_tag;
    icache_pkg::way_vec_t hit_way;
    logic                 fill_en;
    icache_pkg::way_t     fill_way;
    logic                 inval_en;
    icache_pkg::way_t     inval_way;
    icache_pkg::line_t    way_line [icache_pkg::WAY_NUM];
    icache_pkg::way_vec_t data_we;
    icache_pkg::line_t    refill_line;
    logic                 buffer_clear;

    icache_ctrl ctrl_inst (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .req          (req),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd           (rd),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .ret_data     (ret_data),
        .read_index   (read_index),
        .req_index    (req_index),
        .req_tag      (req_tag),
        .hit_way      (hit_way),
        .fill_en      (fill_en),
        .fill_way     (fill_way),
        .inval_en     (inval_en),
        .inval_way    (inval_way),
        .way_line     (way_line),
        .data_we      (data_we),
        .refill_line  (refill_line),
        .buffer_clear (buffer_clear)
    );

    icache_tag_store tag_store_inst (
        .clk        (clk),
        .resetn     (resetn),
        .read_index (read_index),
        .req_index  (req_index),
        .req_tag    (req_tag),
        .hit_way    (hit_way),
        .fill_en    (fill_en),
        .fill_way   (fill_way),
        .inval_en   (inval_en),
        .inval_way  (inval_way)
    );

    icache_refill_buffer refill_buffer_inst (
        .clk       (clk),
        .resetn    (resetn),
        .clear     (buffer_clear),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .line      (refill_line)
    );

    // data ways share the address and take the assembled line on fill
    for (genvar w = 0; w < icache_pkg::WAY_NUM; w++) begin : g_data_way
        icache_way_ram #(
            .entry_t (icache_pkg::line_t)
        ) data_ram (
            .clk   (clk),
            .addr  (read_index),
            .we    (data_we[w]),
            .wdata (refill_line),
            .rdata (way_line[w])
        );
    end

endmodule

//--- testbench/icache_properties.sv
module icache_properties (
    input logic                   clk,
    input logic                   resetn,
    input logic                   valid,
    input icache_pkg::cache_req_t req,
    input logic                   addr_ok,
    input logic                   data_ok,
    input logic                   rd_req,
    input icache_pkg::mem_rd_t    rd,
    input logic                   rd_rdy
);

    int fail_cnt = 0;

    // memory request held until rd_rdy
    rd_hold: assert property (@(posedge clk) disable iff (!resetn)
        rd_req && !rd_rdy |=> rd_req && $stable(rd))
        else begin
            $error("rd_req or rd changed before rd_rdy");
            fail_cnt++;
        end

    // op lookup cycle carries no data_ok
    op_no_data: assert property (@(posedge clk) disable iff (!resetn)
        addr_ok && req.op != icache_pkg::OP_READ |=> !data_ok)
        else begin
            $error("data_ok followed a maintenance op");
            fail_cnt++;
        end

    accept_valid: assert property (@(posedge clk) disable iff (!resetn)
        addr_ok |-> valid)
        else begin
            $error("addr_ok raised without valid");
            fail_cnt++;
        end

endmodule

bind icache_ctrl icache_properties icache_properties_inst (.*);

//--- testbench/icache_tb.sv
module icache_tb;

    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   resetn;
    logic                   valid;
    icache_pkg::cache_req_t req;
    logic                   addr_ok;
    logic                   data_ok;
    icache_pkg::word_t      rdata;
    logic                   rd_req;
    icache_pkg::mem_rd_t    rd;
    logic                   rd_rdy    = 1'b0;
    logic                   ret_valid = 1'b0;
    logic                   ret_last  = 1'b0;
    icache_pkg::word_t      ret_data  = '0;

    // memory model state
    icache_pkg::word_t      beat_addr  = '0;
    int                     beats_left = 0;
    int                     wait_cnt   = 0;
    int                     rdy_delay  = 0;
    int                     rd_count   = 0;
    icache_pkg::mem_rd_t    last_rd;

    int                     error_cnt   = 0;
    int                     timeout_cnt = 0;
    int                     assert_cnt  = 0;
    icache_pkg::way_t       exp_ptr     = '0;
    icache_pkg::way_t       last_fill_way;
    icache_pkg::tag_t       tag_a;
    icache_pkg::index_t     idx_a;

    icache_top icache_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic icache_pkg::word_t model_word(icache_pkg::word_t addr);
        return addr ^ 32'h5a5a0000;
    endfunction

    function automatic icache_pkg::offset_t rand_offset();
        return icache_pkg::offset_t'($urandom_range(3, 0) << 2);
    endfunction

    // rd_rdy after rdy_delay cycles, beats start the cycle after the handshake
    always @(posedge clk) begin
        rd_rdy    <= 1'b0;
        ret_valid <= 1'b0;
        ret_last  <= 1'b0;
        if (beats_left != 0) begin
            ret_valid  <= 1'b1;
            ret_last   <= beats_left == 1;
            ret_data   <= model_word(beat_addr);
            beat_addr  <= beat_addr + 32'd4;
            beats_left <= beats_left - 1;
        end else if (rd_req === 1'b1 && rd_rdy) begin
            last_rd    <= rd;
            rd_count   <= rd_count + 1;
            beat_addr  <= rd.addr;
            beats_left <= rd.rd_type == icache_pkg::RD_LINE ? 4 : 1;
            wait_cnt   <= 0;
        end else if (rd_req === 1'b1) begin
            if (wait_cnt >= rdy_delay) begin
                rd_rdy <= 1'b1;
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

    task automatic compare_word(string name, icache_pkg::word_t got, icache_pkg::word_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic compare_rd(string name, icache_pkg::mem_rd_t got, icache_pkg::mem_rd_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            error_cnt++;
        end
    endtask

    task automatic compare_count(string name, int got, int exp);
        if (got != exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            error_cnt++;
        end
    endtask

    // called right after a rising edge
    task automatic drive_req(icache_pkg::op_t op, icache_pkg::tag_t tag,
                             icache_pkg::index_t index, icache_pkg::offset_t offset,
                             logic uncached);
        icache_pkg::cache_req_t r;
        r.op       = op;
        r.tag      = tag;
        r.index    = index;
        r.offset   = offset;
        r.uncached = uncached;
        rdy_delay  = $urandom_range(3, 0);
        valid     <= 1'b1;
        req       <= r;
    endtask

    task automatic wait_accept();
        int n;
        n = 0;
        @(posedge clk);
        while (addr_ok !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (addr_ok !== 1'b1) begin
            $display("timeout: request was never accepted");
            timeout_cnt++;
        end
    endtask

    task automatic wait_data(output icache_pkg::word_t data);
        int n;
        n = 0;
        @(posedge clk);
        while (data_ok !== 1'b1 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (data_ok !== 1'b1) begin
            $display("timeout: no data_ok after the request was accepted");
            timeout_cnt++;
        end
        data = rdata;
    endtask

    // one read, checking the data and whether memory was read
    task automatic read_check(icache_pkg::tag_t tag, icache_pkg::index_t index,
                              icache_pkg::offset_t offset, logic uncached, bit expect_miss);
        int                  reads_before;
        icache_pkg::word_t   data;
        icache_pkg::mem_rd_t exp_rd;
        reads_before = rd_count;
        drive_req(icache_pkg::OP_READ, tag, index, offset, uncached);
        wait_accept();
        valid <= 1'b0;
        wait_data(data);
        compare_word("rdata", data, model_word({tag, index, offset}));
        compare_count("memory reads", rd_count - reads_before, expect_miss ? 1 : 0);
        if (expect_miss) begin
            exp_rd.rd_type = uncached ? icache_pkg::RD_WORD : icache_pkg::RD_LINE;
            exp_rd.addr    = uncached ? {tag, index, offset} : {tag, index, 4'h0};
            compare_rd("rd", last_rd, exp_rd);
        end
        if (expect_miss && !uncached) begin
            last_fill_way = exp_ptr;
            exp_ptr       = exp_ptr + 1'b1;
        end
    endtask

    task automatic cache_op(icache_pkg::op_t op, icache_pkg::tag_t tag,
                            icache_pkg::index_t index, icache_pkg::offset_t offset);
        drive_req(op, tag, index, offset, 1'b0);
        wait_accept();
        valid <= 1'b0;
        repeat (3) begin
            @(posedge clk);
            if (data_ok !== 1'b0) begin
                $display("data_ok was raised after a maintenance op");
                error_cnt++;
            end
        end
    endtask

    task automatic test_miss_then_hit();
        read_check(tag_a, idx_a, rand_offset(), 1'b0, 1'b1);
        for (int w = 0; w < icache_pkg::WORDS_PER_LINE; w++) begin
            read_check(tag_a, idx_a, icache_pkg::offset_t'(w * 4), 1'b0, 1'b0);
        end
    endtask

    // goes to memory even though the line is resident
    task automatic test_uncached();
        icache_pkg::offset_t off;
        off = rand_offset();
        read_check(tag_a, idx_a, off, 1'b1, 1'b1);
        read_check(tag_a, idx_a, off, 1'b1, 1'b1);
    endtask

    task automatic test_round_robin();
        icache_pkg::index_t idx;
        idx = idx_a + 1;
        read_check(tag_a, idx, rand_offset(), 1'b0, 1'b1);
        read_check(tag_a + 1, idx, rand_offset(), 1'b0, 1'b1);
        read_check(tag_a, idx, rand_offset(), 1'b0, 1'b0);
        read_check(tag_a + 1, idx, rand_offset(), 1'b0, 1'b0);
        // third tag lands on the way of the first
        read_check(tag_a + 2, idx, rand_offset(), 1'b0, 1'b1);
        read_check(tag_a + 1, idx, rand_offset(), 1'b0, 1'b0);
        read_check(tag_a, idx, rand_offset(), 1'b0, 1'b1);
    endtask

    task automatic test_maintenance();
        icache_pkg::index_t idx;
        icache_pkg::way_t   way_t_a;
        idx = idx_a + 2;
        read_check(tag_a, idx, rand_offset(), 1'b0, 1'b1);
        way_t_a = last_fill_way;
        read_check(tag_a + 1, idx, rand_offset(), 1'b0, 1'b1);
        cache_op(icache_pkg::OP_CACOP_IDX0, tag_a + 5, idx, icache_pkg::offset_t'(way_t_a));
        read_check(tag_a + 1, idx, rand_offset(), 1'b0, 1'b0);
        read_check(tag_a, idx, rand_offset(), 1'b0, 1'b1);
        cache_op(icache_pkg::OP_CACOP_HIT, tag_a + 3, idx, '0);
        read_check(tag_a, idx, rand_offset(), 1'b0, 1'b0);
        read_check(tag_a + 1, idx, rand_offset(), 1'b0, 1'b0);
        cache_op(icache_pkg::OP_CACOP_HIT, tag_a, idx, '0);
        read_check(tag_a, idx, rand_offset(), 1'b0, 1'b1);
    endtask

    // second request arrives during the first hit's lookup
    task automatic test_back_to_back();
        icache_pkg::word_t data;
        drive_req(icache_pkg::OP_READ, tag_a, idx_a, 4'h4, 1'b0);
        wait_accept();
        drive_req(icache_pkg::OP_READ, tag_a, idx_a, 4'h8, 1'b0);
        @(posedge clk);
        valid <= 1'b0;
        if (addr_ok !== 1'b1 || data_ok !== 1'b1) begin
            $display("second request not accepted alongside the first hit's data");
            error_cnt++;
        end
        compare_word("rdata", rdata, model_word({tag_a, idx_a, 4'h4}));
        wait_data(data);
        compare_word("rdata", data, model_word({tag_a, idx_a, 4'h8}));
    endtask

    initial begin
        void'($urandom(32'h52e8));
        resetn = 1'b0;
        valid  = 1'b0;
        req    = '0;
        tag_a  = icache_pkg::tag_t'($urandom);
        idx_a  = icache_pkg::index_t'($urandom);
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        test_miss_then_hit();
        test_uncached();
        test_round_robin();
        test_maintenance();
        test_back_to_back();
        assert_cnt = icache_top_inst.ctrl_inst.icache_properties_inst.fail_cnt;
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 error_cnt, timeout_cnt, assert_cnt);
        if (error_cnt == 0 && timeout_cnt == 0 && assert_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- compile.f
verilog/icache_pkg.sv
verilog/icache_way_ram.sv
verilog/icache_tag_store.sv
verilog/icache_refill_buffer.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
testbench/icache_properties.sv
testbench/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - verilog/icache_pkg.sv
  - verilog/icache_way_ram.sv
  - verilog/icache_tag_store.sv
  - verilog/icache_refill_buffer.sv
  - verilog/icache_ctrl.sv
  - verilog/icache_top.sv
  - target: simulation
    files:
      - testbench/icache_properties.sv
      - testbench/icache_tb.sv
